/* source/wb_pkg.sv */
// register bus widths and slave decode values, imported by the decoder and every bus slave
package wb_pkg;

   ////////////////////////////////////////////////////////////
   // bus geometry

   localparam int WB_AW       = 11;   // byte address width
   localparam int WB_DW       = 16;   // data width
   localparam int WB_SW       = 2;    // one select per byte lane
   localparam int SLAVE_SEL_W = 4;    // top address bits used for decode

   typedef logic [WB_AW-1:0]       wb_adr_t;
   typedef logic [WB_DW-1:0]       wb_dat_t;
   typedef logic [WB_SW-1:0]       wb_sel_t;
   typedef logic [SLAVE_SEL_W-1:0] slave_sel_t;

   ////////////////////////////////////////////////////////////
   // slave decode

   localparam slave_sel_t SLAVE_MISC     = 4'd0;
   localparam slave_sel_t SLAVE_READBACK = 4'd7;

   // settings bus covers decode values 8..15, so one bit is enough
   localparam int SETTINGS_DECODE_BIT = 10;

endpackage

/* source/radio_regs_pkg.sv */
// settings and misc register map, readback word map and radio timer types for the control plane
package radio_regs_pkg;

   ////////////////////////////////////////////////////////////
   // settings bus

   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;

   localparam set_addr_t SR_TIME64     = 8'd42;   // +0 pending hi, +1 pending lo, +2 load mode
   localparam set_addr_t SR_REG_TEST32 = 8'd60;

   ////////////////////////////////////////////////////////////
   // misc register slave, decoded on address bits 6..0

   localparam logic [6:0]  REG_CGEN_CTRL   = 7'd4;    // rw
   localparam logic [6:0]  REG_CGEN_ST     = 7'd6;    // ro
   localparam logic [6:0]  REG_TEST        = 7'd8;    // rw scratch
   localparam logic [15:0] MISC_FILLER     = 16'hBEEF;
   localparam logic [1:0]  CGEN_CTRL_RESET = 2'b11;   // sync_b and ref_sel idle high

   ////////////////////////////////////////////////////////////
   // readback mux

   // bump when the register map changes in an incompatible way
   localparam set_data_t COMPAT_NUM = {16'd9, 16'd2};   // major, minor

   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;
   localparam logic [3:0] RB_COMPAT  = 4'd6;

endpackage

/* source/wb_slave_if.sv */
// one decoded register bus slave port, driven by the decoder and answered by a slave
`timescale 1ns/1ns

interface wb_slave_if import wb_pkg::*; ();

   wb_adr_t adr;
   wb_dat_t dat_w;    // master to slave
   wb_dat_t dat_r;    // slave to master
   wb_sel_t sel;
   logic    we;
   logic    cyc;
   logic    stb;
   logic    ack;

   modport master
   (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack
   );

   modport slave
   (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack
   );

endinterface

/* source/wb_decoder.sv */
// single master register bus decoder, steers strobes to misc, readback and settings slaves
`timescale 1ns/1ns

module wb_decoder import wb_pkg::*;
(
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   input  logic       wb_we_i,
   input  wb_adr_t    wb_adr_i,
   input  wb_dat_t    wb_dat_i,
   input  wb_sel_t    wb_sel_i,
   output wb_dat_t    wb_dat_o,
   output logic       wb_ack_o,
   wb_slave_if.master misc_o,
   wb_slave_if.master rb_o,
   wb_slave_if.master set_o
);

   slave_sel_t slave_sel;
   logic       hit_set;
   logic       hit_misc;
   logic       hit_rb;

   assign slave_sel = wb_adr_i[WB_AW-1 -: SLAVE_SEL_W];
   assign hit_set   = wb_adr_i[SETTINGS_DECODE_BIT];
   assign hit_misc  = ~hit_set & (slave_sel == SLAVE_MISC);
   assign hit_rb    = ~hit_set & (slave_sel == SLAVE_READBACK);

   ////////////////////////////////////////////////////////////
   // request side, shared fields fan out, strobes are gated

   assign misc_o.adr   = wb_adr_i;
   assign misc_o.dat_w = wb_dat_i;
   assign misc_o.sel   = wb_sel_i;
   assign misc_o.we    = wb_we_i;
   assign misc_o.cyc   = wb_cyc_i & hit_misc;
   assign misc_o.stb   = wb_stb_i & hit_misc;

   assign rb_o.adr     = wb_adr_i;
   assign rb_o.dat_w   = wb_dat_i;
   assign rb_o.sel     = wb_sel_i;
   assign rb_o.we      = wb_we_i;
   assign rb_o.cyc     = wb_cyc_i & hit_rb;
   assign rb_o.stb     = wb_stb_i & hit_rb;

   assign set_o.adr    = wb_adr_i;
   assign set_o.dat_w  = wb_dat_i;
   assign set_o.sel    = wb_sel_i;
   assign set_o.we     = wb_we_i;
   assign set_o.cyc    = wb_cyc_i & hit_set;
   assign set_o.stb    = wb_stb_i & hit_set;

   ////////////////////////////////////////////////////////////
   // response side

   always_comb
   begin
      wb_dat_o = '0;      // unmapped space reads zero and never acks
      wb_ack_o = 1'b0;
      if (hit_set)
      begin
         wb_dat_o = set_o.dat_r;
         wb_ack_o = set_o.ack;
      end
      else if (hit_misc)
      begin
         wb_dat_o = misc_o.dat_r;
         wb_ack_o = misc_o.ack;
      end
      else if (hit_rb)
      begin
         wb_dat_o = rb_o.dat_r;
         wb_ack_o = rb_o.ack;
      end
   end

endmodule

/* source/misc_regs.sv */
// misc register slave with clock generator control and status plus a scratch register
`timescale 1ns/1ns

module misc_regs import wb_pkg::*, radio_regs_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   wb_slave_if.slave bus_i,
   input  logic      cgen_st_status_i,
   input  logic      cgen_st_ld_i,
   input  logic      cgen_st_refmon_i,
   output logic      cgen_sync_b_o,
   output logic      cgen_ref_sel_o
);

   wb_dat_t    reg_cgen_ctrl;
   wb_dat_t    reg_test;
   logic [6:0] reg_adr;
   logic       wr_en;

   assign reg_adr = bus_i.adr[6:0];
   assign wr_en   = bus_i.cyc & bus_i.stb & bus_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_cgen_ctrl <= {14'd0, CGEN_CTRL_RESET};
         reg_test      <= '0;
      end
      else if (wr_en)
      begin
         if (reg_adr == REG_CGEN_CTRL)
            reg_cgen_ctrl <= bus_i.dat_w;
         // scratch honours the byte lanes
         if (reg_adr == REG_TEST && bus_i.sel[1])
            reg_test[15:8] <= bus_i.dat_w[15:8];
         if (reg_adr == REG_TEST && bus_i.sel[0])
            reg_test[7:0] <= bus_i.dat_w[7:0];
      end
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];

   always_comb
   begin
      case (reg_adr)
         REG_CGEN_CTRL : bus_i.dat_r = reg_cgen_ctrl;
         REG_CGEN_ST   : bus_i.dat_r = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST      : bus_i.dat_r = reg_test;
         default       : bus_i.dat_r = MISC_FILLER;
      endcase
   end

   assign bus_i.ack = bus_i.stb & bus_i.cyc;   // zero wait state

endmodule

/* source/settings_bus.sv */
// joins pairs of 16-bit register bus writes into 32-bit settings bus strobes
`timescale 1ns/1ns

module settings_bus import wb_pkg::*, radio_regs_pkg::*;
(
   input  logic      wb_clk,
   input  logic      wb_rst,
   wb_slave_if.slave bus_i,
   output logic      set_stb_o,
   output set_addr_t set_addr_o,
   output set_data_t set_data_o
);

   wb_dat_t low_half;    // held until the high half arrives
   logic    ack_r;
   logic    done_r;      // access already answered, wait for stb to drop
   logic    take;

   assign take = bus_i.cyc & bus_i.stb & ~ack_r & ~done_r;

   ////////////////////////////////////////////////////////////
   // handshake and strobe

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_r     <= 1'b0;
         done_r    <= 1'b0;
         set_stb_o <= 1'b0;
      end
      else
      begin
         ack_r     <= take;
         set_stb_o <= take & bus_i.we & bus_i.adr[1];   // lines up with the ack
         if (!bus_i.stb)
            done_r <= 1'b0;
         else if (ack_r)
            done_r <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // data path

   always_ff @(posedge wb_clk)
   begin
      if (take & bus_i.we)
      begin
         if (bus_i.adr[1])
         begin
            set_addr_o <= bus_i.adr[SETTINGS_DECODE_BIT-1:2];
            set_data_o <= {bus_i.dat_w, low_half};
         end
         else
            low_half <= bus_i.dat_w;
      end
   end

   assign bus_i.ack   = ack_r;
   assign bus_i.dat_r = '0;   // write only

endmodule

/* source/vita_timer.sv */
// 64-bit radio time counter, loaded from the settings bus at once or on the next PPS edge
`timescale 1ns/1ns

module vita_timer import radio_regs_pkg::*;
#(
   parameter set_addr_t BASE = SR_TIME64
)
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       pps_i,
   output vita_time_t vita_time_o,
   output vita_time_t vita_time_pps_o
);

   set_data_t  pending_hi;
   set_data_t  pending_lo;
   vita_time_t pending;
   logic       wr_hi;
   logic       wr_lo;
   logic       wr_mode;
   logic       load_now_r;   // immediate load, one cycle after the mode write
   logic       armed_r;      // load waits for the next PPS edge
   logic [1:0] pps_sync;
   logic       pps_last;
   logic       pps_edge;

   assign wr_hi   = set_stb_i & (set_addr_i == BASE);
   assign wr_lo   = set_stb_i & (set_addr_i == set_addr_t'(BASE + 1));
   assign wr_mode = set_stb_i & (set_addr_i == set_addr_t'(BASE + 2));
   assign pending = {pending_hi, pending_lo};

   always_ff @(posedge wb_clk)
   begin
      if (wr_hi)
         pending_hi <= set_data_i;
      if (wr_lo)
         pending_lo <= set_data_i;
   end

   ////////////////////////////////////////////////////////////
   // PPS synchronizer and rising edge

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= '0;
         pps_last <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[0], pps_i};
         pps_last <= pps_sync[1];
      end
   end

   assign pps_edge = pps_sync[1] & ~pps_last;

   ////////////////////////////////////////////////////////////
   // load control

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         load_now_r <= 1'b0;
         armed_r    <= 1'b0;
      end
      else
      begin
         load_now_r <= wr_mode & set_data_i[0];
         if (wr_mode)
            armed_r <= ~set_data_i[0];
         else if (pps_edge)
            armed_r <= 1'b0;   // one shot
      end
   end

   ////////////////////////////////////////////////////////////
   // counter and PPS latch

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         if (load_now_r | (pps_edge & armed_r))
            vita_time_o <= pending;
         else
            vita_time_o <= vita_time_o + 64'd1;
         if (pps_edge)
            vita_time_pps_o <= armed_r ? pending : vita_time_o;
      end
   end

endmodule

/* source/readback_mux.sv */
// serves 32-bit status words as 16-bit halves on the register bus, holds the test32 setting
`timescale 1ns/1ns

module readback_mux import wb_pkg::*, radio_regs_pkg::*;
#(
   parameter set_addr_t TEST32_ADDR = SR_REG_TEST32
)
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   wb_slave_if.slave  bus_i,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  vita_time_t vita_time_i,
   input  vita_time_t vita_time_pps_i
);

   set_data_t  test32_r;
   set_data_t  word;
   logic [3:0] word_idx;
   wb_dat_t    dat_r;
   logic       ack_r;
   logic       done_r;
   logic       take;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         test32_r <= '0;
      else if (set_stb_i && set_addr_i == TEST32_ADDR)
         test32_r <= set_data_i;
   end

   ////////////////////////////////////////////////////////////
   // word select

   assign word_idx = bus_i.adr[5:2];

   always_comb
   begin
      case (word_idx)
         RB_TIME_HI : word = vita_time_i[63:32];
         RB_TIME_LO : word = vita_time_i[31:0];
         RB_PPS_HI  : word = vita_time_pps_i[63:32];
         RB_PPS_LO  : word = vita_time_pps_i[31:0];
         RB_TEST32  : word = test32_r;
         RB_COMPAT  : word = COMPAT_NUM;
         default    : word = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // registered half and ack

   assign take = bus_i.cyc & bus_i.stb & ~ack_r & ~done_r;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_r  <= 1'b0;
         done_r <= 1'b0;
      end
      else
      begin
         ack_r <= take;
         if (!bus_i.stb)
            done_r <= 1'b0;
         else if (ack_r)
            done_r <= 1'b1;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (take)
         dat_r <= bus_i.adr[1] ? word[31:16] : word[15:0];   // bit 1 picks the high half
   end

   assign bus_i.dat_r = dat_r;
   assign bus_i.ack   = ack_r;

endmodule

/* source/radio_ctrl_top.sv */
// control plane top level of the radio core, one register bus master port in, slaves below
`timescale 1ns/1ns

module radio_ctrl_top import wb_pkg::*, radio_regs_pkg::*;
#(
   parameter set_addr_t TIME_BASE   = SR_TIME64,
   parameter set_addr_t TEST32_ADDR = SR_REG_TEST32
)
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   // register bus master
   input  logic    wb_cyc_i,
   input  logic    wb_stb_i,
   input  logic    wb_we_i,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  wb_sel_t wb_sel_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,
   // clock generator
   input  logic    cgen_st_status_i,
   input  logic    cgen_st_ld_i,
   input  logic    cgen_st_refmon_i,
   output logic    cgen_sync_b_o,
   output logic    cgen_ref_sel_o,
   input  logic    pps_i
);

   logic       set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   wb_slave_if misc_bus ();
   wb_slave_if rb_bus ();
   wb_slave_if set_bus ();

   ////////////////////////////////////////////////////////////
   // bus decode

   wb_decoder u_decoder
   (
      .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_we_i  (wb_we_i),
      .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_sel_i (wb_sel_i),
      .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
      .misc_o   (misc_bus), .rb_o     (rb_bus),   .set_o    (set_bus)
   );

   ////////////////////////////////////////////////////////////
   // slaves

   misc_regs u_misc_regs
   (
      .wb_clk           (wb_clk),           .wb_rst         (wb_rst),
      .bus_i            (misc_bus),
      .cgen_st_status_i (cgen_st_status_i), .cgen_st_ld_i   (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i),
      .cgen_sync_b_o    (cgen_sync_b_o),    .cgen_ref_sel_o (cgen_ref_sel_o)
   );

   settings_bus u_settings_bus
   (
      .wb_clk     (wb_clk),   .wb_rst     (wb_rst),   .bus_i      (set_bus),
      .set_stb_o  (set_stb),  .set_addr_o (set_addr), .set_data_o (set_data)
   );

   readback_mux #(.TEST32_ADDR(TEST32_ADDR)) u_readback_mux
   (
      .wb_clk      (wb_clk),    .wb_rst          (wb_rst),        .bus_i      (rb_bus),
      .set_stb_i   (set_stb),   .set_addr_i      (set_addr),      .set_data_i (set_data),
      .vita_time_i (vita_time), .vita_time_pps_i (vita_time_pps)
   );

   ////////////////////////////////////////////////////////////
   // radio time

   vita_timer #(.BASE(TIME_BASE)) u_vita_timer
   (
      .wb_clk      (wb_clk),    .wb_rst          (wb_rst),
      .set_stb_i   (set_stb),   .set_addr_i      (set_addr),      .set_data_i (set_data),
      .pps_i       (pps_i),
      .vita_time_o (vita_time), .vita_time_pps_o (vita_time_pps)
   );

endmodule

/* verification/radio_ctrl_checker.sv */
// bus protocol and reset assertions, bound into the control plane top level during simulation
`timescale 1ns/1ns

module radio_ctrl_checker import wb_pkg::*;
(
   input logic    wb_clk,
   input logic    wb_rst,
   input logic    cyc_i,
   input logic    stb_i,
   input wb_adr_t adr_i,
   input logic    ack_i,
   input logic    sync_b_i,
   input logic    ref_sel_i
);

   logic rst_held = 1'b0;   // reset was also high on the previous edge
   logic reg_slave;         // settings bus or readback mux, both ack one cycle late
   int   fail_count = 0;    // failed assertions so far

   assign reg_slave = adr_i[SETTINGS_DECODE_BIT]
                    | (adr_i[WB_AW-1 -: SLAVE_SEL_W] == SLAVE_READBACK);

   always @(posedge wb_clk)
      rst_held <= wb_rst;

   ////////////////////////////////////////////////////////////
   // bus protocol

   ack_with_strobe : assert property (@(posedge wb_clk) disable iff (wb_rst)
      ack_i |-> cyc_i && stb_i)
      else
      begin
         fail_count++;
         $error("ack seen without cyc and stb");
      end

   ack_single_cycle : assert property (@(posedge wb_clk) disable iff (wb_rst)
      ack_i && reg_slave |=> !ack_i)
      else
      begin
         fail_count++;
         $error("registered ack held for two cycles");
      end

   ////////////////////////////////////////////////////////////
   // reset

   cgen_idle_in_reset : assert property (@(posedge wb_clk)
      wb_rst && rst_held |-> sync_b_i && ref_sel_i)
      else
      begin
         fail_count++;
         $error("cgen outputs not high during reset");
      end

endmodule

bind radio_ctrl_top radio_ctrl_checker u_checker
(
   .wb_clk    (wb_clk),
   .wb_rst    (wb_rst),
   .cyc_i     (wb_cyc_i),
   .stb_i     (wb_stb_i),
   .adr_i     (wb_adr_i),
   .ack_i     (wb_ack_o),
   .sync_b_i  (cgen_sync_b_o),
   .ref_sel_i (cgen_ref_sel_o)
);

/* verification/radio_ctrl_tb.sv */
// testbench for the radio control plane, drives the register bus and checks the register map
`timescale 1ns/1ns

module radio_ctrl_tb import wb_pkg::*, radio_regs_pkg::*; ();

   localparam int ACK_TIMEOUT = 20;   // cycles a master waits for ack

   logic    wb_clk;
   logic    wb_rst;
   logic    wb_cyc_i;
   logic    wb_stb_i;
   logic    wb_we_i;
   wb_adr_t wb_adr_i;
   wb_dat_t wb_dat_i;
   wb_sel_t wb_sel_i;
   wb_dat_t wb_dat_o;
   logic    wb_ack_o;
   logic    cgen_st_status_i;
   logic    cgen_st_ld_i;
   logic    cgen_st_refmon_i;
   logic    cgen_sync_b_o;
   logic    cgen_ref_sel_o;
   logic    pps_i;

   logic [31:0] rng_state = 32'd46178;
   int          errors = 0;
   int          test_errors = 0;
   int          checks = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   radio_ctrl_top u_dut
   (
      .wb_clk           (wb_clk),           .wb_rst           (wb_rst),
      .wb_cyc_i         (wb_cyc_i),         .wb_stb_i         (wb_stb_i),
      .wb_we_i          (wb_we_i),          .wb_adr_i         (wb_adr_i),
      .wb_dat_i         (wb_dat_i),         .wb_sel_i         (wb_sel_i),
      .wb_dat_o         (wb_dat_o),         .wb_ack_o         (wb_ack_o),
      .cgen_st_status_i (cgen_st_status_i), .cgen_st_ld_i     (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i), .cgen_sync_b_o    (cgen_sync_b_o),
      .cgen_ref_sel_o   (cgen_ref_sel_o),   .pps_i            (pps_i)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #20 wb_clk = ~wb_clk;
   end

   ////////////////////////////////////////////////////////////
   // helpers

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state;
   endfunction

   function automatic wb_adr_t rb_addr(input logic [3:0] idx, input logic hi);
      return {SLAVE_READBACK, 1'b0, idx, hi, 1'b0};
   endfunction

   function automatic wb_adr_t setting_addr(input set_addr_t adr, input logic hi);
      return {1'b1, adr, hi, 1'b0};   // bit 10 picks the settings bus
   endfunction

   task automatic compare(input string what, input wb_dat_t got, input wb_dat_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         test_errors++;
         $display("error at %0t ns: %0s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   // one access, ack sampled on the rising edge, strobes dropped on the next falling edge
   task automatic run_cycle(input logic we, input wb_adr_t adr, input wb_dat_t wdat,
                            output wb_dat_t rdat, output logic acked);
      int waited;
      waited = 0;
      acked  = 1'b0;
      rdat   = '0;
      @(negedge wb_clk);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      wb_sel_i = 2'b11;
      while (!acked && waited < ACK_TIMEOUT)
      begin
         @(posedge wb_clk);
         waited++;
         if (wb_ack_o)
         begin
            acked = 1'b1;
            rdat  = wb_dat_o;
         end
      end
      @(negedge wb_clk);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_word(input wb_adr_t adr, input wb_dat_t dat);
      wb_dat_t unused;
      logic    acked;
      run_cycle(1'b1, adr, dat, unused, acked);
      if (!acked)
      begin
         errors++;
         test_errors++;
         $display("write to address %h got no ack within %0d cycles", adr, ACK_TIMEOUT);
      end
   endtask

   task automatic read_word(input wb_adr_t adr, output wb_dat_t dat);
      logic acked;
      run_cycle(1'b0, adr, 16'd0, dat, acked);
      if (!acked)
      begin
         errors++;
         test_errors++;
         $display("read from address %h got no ack within %0d cycles", adr, ACK_TIMEOUT);
      end
   endtask

   task automatic write_setting(input set_addr_t adr, input set_data_t dat);
      write_word(setting_addr(adr, 1'b0), dat[15:0]);    // low half is held
      write_word(setting_addr(adr, 1'b1), dat[31:16]);   // high half fires the strobe
   endtask

   task automatic read_pair(input logic [3:0] idx, output set_data_t dat);
      wb_dat_t hi;
      wb_dat_t lo;
      read_word(rb_addr(idx, 1'b1), hi);
      read_word(rb_addr(idx, 1'b0), lo);
      dat = {hi, lo};
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (test_errors == 0)
         $display("test %0s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %0s: %0d errors", name, test_errors);
      end
      test_errors = 0;
   endtask

   ////////////////////////////////////////////////////////////
   // tests

   initial
   begin
      logic [31:0] rnd;
      wb_dat_t     rdat;
      wb_dat_t     scratch;
      set_data_t   word;
      set_data_t   test32;
      set_data_t   time_hi;
      set_data_t   pps_hi;
      set_data_t   pps_lo;
      logic        acked;

      wb_rst           = 1'b1;
      wb_cyc_i         = 1'b0;
      wb_stb_i         = 1'b0;
      wb_we_i          = 1'b0;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_sel_i         = '0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      pps_i            = 1'b0;
      scratch          = '0;
      repeat (16) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      compare("cgen pins after reset", wb_dat_t'({cgen_sync_b_o, cgen_ref_sel_o}), 16'd3);
      read_word({SLAVE_MISC, REG_CGEN_CTRL}, rdat);
      compare("cgen ctrl after reset", rdat, 16'd3);
      read_word({SLAVE_MISC, REG_TEST}, rdat);
      compare("scratch after reset", rdat, 16'd0);
      read_word({SLAVE_MISC, 7'd2}, rdat);
      compare("misc filler", rdat, 16'hBEEF);
      close_test("reset_state");

      repeat (4)
      begin
         rnd     = next_rand();
         scratch = rnd[31:16];
         write_word({SLAVE_MISC, REG_TEST}, scratch);
         read_word({SLAVE_MISC, REG_TEST}, rdat);
         compare("scratch readback", rdat, scratch);
      end
      write_word({SLAVE_MISC, REG_CGEN_CTRL}, 16'd0);
      compare("cgen pins after clear", wb_dat_t'({cgen_sync_b_o, cgen_ref_sel_o}), 16'd0);
      cgen_st_status_i = 1'b1;   // status, ld, refmon = 100
      read_word({SLAVE_MISC, REG_CGEN_ST}, rdat);
      compare("cgen status 100", rdat, 16'h0004);
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b1;
      cgen_st_refmon_i = 1'b1;
      read_word({SLAVE_MISC, REG_CGEN_ST}, rdat);
      compare("cgen status 011", rdat, 16'h0003);
      close_test("misc_regs");

      test32 = next_rand();
      write_setting(SR_REG_TEST32, test32);
      read_pair(RB_TEST32, word);
      compare("test32 high half", word[31:16], test32[31:16]);
      compare("test32 low half", word[15:0], test32[15:0]);
      read_pair(RB_COMPAT, word);
      compare("compat major", word[31:16], 16'd9);
      compare("compat minor", word[15:0], 16'd2);
      close_test("settings_readback");

      time_hi = next_rand();
      write_setting(SR_TIME64, time_hi);
      write_setting(SR_TIME64 + 8'd1, 32'd0);
      write_setting(SR_TIME64 + 8'd2, 32'd1);   // immediate load
      read_pair(RB_TIME_HI, word);
      compare("time high word, upper half", word[31:16], time_hi[31:16]);
      compare("time high word, lower half", word[15:0], time_hi[15:0]);
      read_pair(RB_TIME_LO, word);
      checks++;
      assert (word > 32'd0 && word < 32'd200)
      else
      begin
         errors++;
         test_errors++;
         $display("error at %0t ns: time low word %0d outside 1..199", $time, word);
      end
      close_test("time_load_now");

      pps_hi = next_rand();
      pps_lo = next_rand();
      write_setting(SR_TIME64, pps_hi);
      write_setting(SR_TIME64 + 8'd1, pps_lo);
      write_setting(SR_TIME64 + 8'd2, 32'd0);   // arm for the next pps
      @(negedge wb_clk);
      pps_i = 1'b1;
      repeat (4) @(negedge wb_clk);
      pps_i = 1'b0;
      read_pair(RB_PPS_HI, word);
      compare("pps latch, upper half of high word", word[31:16], pps_hi[31:16]);
      compare("pps latch, lower half of high word", word[15:0], pps_hi[15:0]);
      read_pair(RB_PPS_LO, word);
      compare("pps latch, upper half of low word", word[31:16], pps_lo[31:16]);
      compare("pps latch, lower half of low word", word[15:0], pps_lo[15:0]);
      close_test("time_load_pps");

      run_cycle(1'b0, {4'd1, 7'd0}, 16'd0, rdat, acked);
      checks++;
      assert (!acked)
      else
      begin
         errors++;
         test_errors++;
         $display("error at %0t ns: access at decode value 1 was acknowledged", $time);
      end
      if (!acked)
         $display("no ack at decode value 1 within %0d cycles, as expected", ACK_TIMEOUT);
      read_word({SLAVE_MISC, REG_TEST}, rdat);
      compare("scratch after unmapped access", rdat, scratch);
      close_test("unmapped_decode");

      $display("%0d tests run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
               tests_run, tests_failed, checks, errors, u_dut.u_checker.fail_count);
      if (errors == 0 && u_dut.u_checker.fail_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* filelist.f */
source/wb_pkg.sv
source/radio_regs_pkg.sv
source/wb_slave_if.sv
source/wb_decoder.sv
source/misc_regs.sv
source/settings_bus.sv
source/vita_timer.sv
source/readback_mux.sv
source/radio_ctrl_top.sv
verification/radio_ctrl_checker.sv
verification/radio_ctrl_tb.sv

/* Makefile */
# Verilator build and run of the radio control plane testbench

SRCS := $(filter-out +%,$(shell cat filelist.f))

.PHONY: run clean

run: obj_dir/Vradio_ctrl_tb
	obj_dir/Vradio_ctrl_tb | tee sim.log
	grep -q 'All tests passed!' sim.log

obj_dir/Vradio_ctrl_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module radio_ctrl_tb -f filelist.f

clean:
	rm -rf obj_dir sim.log
